/* hdl/ioCfg.svh */
`ifndef IO_CFG_SVH
`define IO_CFG_SVH

// Width of addresses and data words on the command bus
`define IO_DATA_WIDTH 16

// First address of the I/O window
`define IO_BASE_ADDR 384

// Timers occupy offsets 0 to IO_TIMER_COUNT-1
`define IO_TIMER_COUNT 4

// Ports follow the timers, one word each
`define IO_PORT_COUNT 4

// Every timer and every port owns one response slot
`define IO_SOURCE_COUNT (`IO_TIMER_COUNT + `IO_PORT_COUNT)

`endif

/* hdl/ioPkg.sv */
`include "ioCfg.svh"

package ioPkg;

    // Decoded from the minor opcode, store has priority
    typedef enum logic [1:0] {
        ioKindNone  = 2'd0,
        ioKindLoad  = 2'd1,
        ioKindStore = 2'd2
    } ioKindE;

    // Command as it arrives from the core
    typedef struct packed {
        logic [3:0]                minorOpcode;
        logic [`IO_DATA_WIDTH-1:0] address;
        logic [`IO_DATA_WIDTH-1:0] data;
        logic [3:0]                destReg;
    } ioCommandT;

    // Broadcast from the router to every device
    typedef struct packed {
        ioKindE                    kind;
        logic [3:0]                localIndex;
        logic [`IO_DATA_WIDTH-1:0] data;
        logic [3:0]                destReg;
    } ioDeviceCmdT;

    typedef struct packed {
        logic [3:0]                destReg;
        logic [`IO_DATA_WIDTH-1:0] data;
    } ioWritebackT;

endpackage

/* hdl/commandRouter.sv */
`timescale 1ns/1ps
`include "ioCfg.svh"

module commandRouter
    import ioPkg::*;
(
    input  logic                       sys_clk,
    input  logic                       rstN,
    input  logic                       commandAck,
    input  ioCommandT                  command,
    output logic                       commandReq,
    output ioDeviceCmdT                deviceCmd,
    output logic [`IO_TIMER_COUNT-1:0] timerValid,
    output logic [`IO_PORT_COUNT-1:0]  portValid,
    input  logic [`IO_TIMER_COUNT-1:0] timerReady,
    input  logic [`IO_PORT_COUNT-1:0]  portReady
);

    localparam logic [`IO_DATA_WIDTH-1:0] BaseAddr   = `IO_BASE_ADDR;
    localparam logic [`IO_DATA_WIDTH-1:0] TimerLimit = `IO_TIMER_COUNT;
    localparam logic [`IO_DATA_WIDTH-1:0] PortLimit  = `IO_SOURCE_COUNT;

    ioCommandT                 held;
    logic                      heldFull;
    logic                      reqArmed;
    logic [`IO_DATA_WIDTH-1:0] offset;
    logic [`IO_DATA_WIDTH-1:0] portOffset;
    logic                      timerHit;
    logic                      portHit;
    ioKindE                    kind;
    logic                      targetLive;
    logic                      taken;
    logic                      dropHeld;
    logic                      drain;
    logic                      accept;

    always_comb begin
        if (held.minorOpcode[2]) begin
            kind = ioKindStore;
        end else if (held.minorOpcode[3]) begin
            kind = ioKindLoad;
        end else begin
            kind = ioKindNone;
        end
    end

    // Offsets below the base wrap to large values and miss both ranges
    assign offset     = held.address - BaseAddr;
    assign portOffset = offset - TimerLimit;
    assign timerHit   = offset < TimerLimit;
    assign portHit    = !timerHit && (offset < PortLimit);

    assign deviceCmd.kind       = kind;
    assign deviceCmd.localIndex = timerHit ? offset[3:0] : portOffset[3:0];
    assign deviceCmd.data       = held.data;
    assign deviceCmd.destReg    = held.destReg;

    assign targetLive = heldFull && (kind != ioKindNone);

    // Only the addressed device sees valid
    always_comb begin
        taken = 1'b0;
        for (int i = 0; i < `IO_TIMER_COUNT; i++) begin
            timerValid[i] = targetLive && timerHit && (deviceCmd.localIndex == i);
            taken = taken | (timerValid[i] & timerReady[i]);
        end
        for (int i = 0; i < `IO_PORT_COUNT; i++) begin
            portValid[i] = targetLive && portHit && (deviceCmd.localIndex == i);
            taken = taken | (portValid[i] & portReady[i]);
        end
    end

    assign dropHeld   = heldFull && ((kind == ioKindNone) || !(timerHit || portHit));
    assign drain      = taken || dropHeld;
    assign commandReq = reqArmed && (!heldFull || drain);
    assign accept     = commandAck && commandReq;

    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            heldFull <= 1'b0;
            reqArmed <= 1'b0;
        end else begin
            reqArmed <= 1'b1;
            if (accept) begin
                heldFull <= 1'b1;
            end else if (drain) begin
                heldFull <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            held <= command;
        end
    end

endmodule

/* hdl/ioTimers.sv */
`timescale 1ns/1ps
`include "ioCfg.svh"

module ioTimers
    import ioPkg::*;
(
    input  logic                              sys_clk,
    input  logic                              rstN,
    input  ioDeviceCmdT                       deviceCmd,
    input  logic [`IO_TIMER_COUNT-1:0]        timerValid,
    output logic [`IO_TIMER_COUNT-1:0]        timerReady,
    output ioWritebackT [`IO_TIMER_COUNT-1:0] response,
    output logic [`IO_TIMER_COUNT-1:0]        responseValid,
    input  logic [`IO_TIMER_COUNT-1:0]        grant
);

    logic [`IO_TIMER_COUNT-1:0][`IO_DATA_WIDTH-1:0] reload;
    logic [`IO_TIMER_COUNT-1:0][`IO_DATA_WIDTH-1:0] count;
    logic [`IO_TIMER_COUNT-1:0][3:0]                timerDest;
    logic [`IO_TIMER_COUNT-1:0]                     active;
    logic [`IO_TIMER_COUNT-1:0]                     expired;
    logic [`IO_TIMER_COUNT-1:0]                     fire;
    logic [`IO_TIMER_COUNT-1:0]                     takeStore;
    logic [`IO_TIMER_COUNT-1:0]                     takeLoad;

    always_comb begin
        for (int i = 0; i < `IO_TIMER_COUNT; i++) begin
            expired[i]    = active[i] && (count[i] == '0);
            // Expiry waits at zero while the slot is still occupied
            fire[i]       = expired[i] && (!responseValid[i] || grant[i]);
            // Expiry owns the slot in its cycle, so no command is taken then
            timerReady[i] = !responseValid[i] && !expired[i];
            takeStore[i]  = timerValid[i] && timerReady[i] && (deviceCmd.kind == ioKindStore);
            takeLoad[i]   = timerValid[i] && timerReady[i] && (deviceCmd.kind == ioKindLoad);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            active        <= '0;
            responseValid <= '0;
            reload        <= '0;
        end else begin
            for (int i = 0; i < `IO_TIMER_COUNT; i++) begin
                if (takeStore[i]) begin
                    active[i] <= 1'b1;
                    reload[i] <= deviceCmd.data;
                end else if (fire[i]) begin
                    active[i] <= 1'b0;
                end
                if (grant[i]) begin
                    responseValid[i] <= 1'b0;
                end
                if (fire[i] || takeLoad[i]) begin
                    responseValid[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        for (int i = 0; i < `IO_TIMER_COUNT; i++) begin
            if (takeStore[i]) begin
                count[i]     <= deviceCmd.data;
                timerDest[i] <= deviceCmd.destReg;
            end else if (active[i] && !expired[i]) begin
                count[i] <= count[i] - 1'b1;
            end
            // Both responses carry the reload value
            if (fire[i]) begin
                response[i] <= '{destReg: timerDest[i], data: reload[i]};
            end else if (takeLoad[i]) begin
                response[i] <= '{destReg: deviceCmd.destReg, data: reload[i]};
            end
        end
    end

endmodule

/* hdl/portController.sv */
`timescale 1ns/1ps
`include "ioCfg.svh"

module portController
    import ioPkg::*;
(
    input  logic                      sys_clk,
    input  logic                      rstN,
    input  ioDeviceCmdT               deviceCmd,
    input  logic                      cmdValid,
    output logic                      cmdReady,
    input  logic [`IO_DATA_WIDTH-1:0] pinsIn,
    output logic [`IO_DATA_WIDTH-1:0] pinsOut,
    output ioWritebackT               response,
    output logic                      responseValid,
    input  logic                      grant
);

    logic [`IO_DATA_WIDTH-1:0] syncStage1;
    logic [`IO_DATA_WIDTH-1:0] syncStage2;
    logic                      take;
    logic                      takeStore;
    logic                      takeLoad;

    // A full slot blocks both kinds of command
    assign cmdReady  = !responseValid;
    assign take      = cmdValid && cmdReady;
    assign takeStore = take && (deviceCmd.kind == ioKindStore);
    assign takeLoad  = take && (deviceCmd.kind == ioKindLoad);

    // Pins are asynchronous to sys_clk
    always_ff @(posedge sys_clk) begin
        syncStage1 <= pinsIn;
        syncStage2 <= syncStage1;
    end

    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            pinsOut       <= '0;
            responseValid <= 1'b0;
        end else begin
            if (takeStore) begin
                pinsOut <= deviceCmd.data;
            end
            if (takeLoad) begin
                responseValid <= 1'b1;
            end else if (grant) begin
                responseValid <= 1'b0;
            end
        end
    end

    // Load returns the synchronized pin value
    always_ff @(posedge sys_clk) begin
        if (takeLoad) begin
            response.destReg <= deviceCmd.destReg;
            response.data    <= syncStage2;
        end
    end

endmodule

/* hdl/writebackArbiter.sv */
`timescale 1ns/1ps
`include "ioCfg.svh"

module writebackArbiter
    import ioPkg::*;
(
    input  logic                               sys_clk,
    input  logic                               rstN,
    input  ioWritebackT [`IO_SOURCE_COUNT-1:0] sourceData,
    input  logic [`IO_SOURCE_COUNT-1:0]        sourceValid,
    output logic [`IO_SOURCE_COUNT-1:0]        grant,
    output logic                               writebackAck,
    input  logic                               writebackReq,
    output ioWritebackT                        writeback
);

    localparam int PtrWidth = $clog2(`IO_SOURCE_COUNT);
    localparam logic [PtrWidth-1:0] LastSource = PtrWidth'(`IO_SOURCE_COUNT - 1);

    logic [PtrWidth-1:0] pointer;
    logic [PtrWidth-1:0] winner;
    logic                found;
    logic                loadOut;

    // Output register is free when empty or draining this cycle
    assign loadOut = !writebackAck || writebackReq;

    // Search starts at the pointer and wraps around
    always_comb begin
        int idx;
        found  = 1'b0;
        winner = '0;
        for (int k = 0; k < `IO_SOURCE_COUNT; k++) begin
            idx = (int'(pointer) + k) % `IO_SOURCE_COUNT;
            if (!found && sourceValid[idx]) begin
                found  = 1'b1;
                winner = PtrWidth'(idx);
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found && loadOut) begin
            grant[winner] = 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            writebackAck <= 1'b0;
            pointer      <= '0;
        end else if (loadOut) begin
            writebackAck <= found;
            if (found) begin
                pointer <= (winner == LastSource) ? '0 : winner + 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (loadOut && found) begin
            writeback <= sourceData[winner];
        end
    end

endmodule

/* hdl/ioManager.sv */
`timescale 1ns/1ps
`include "ioCfg.svh"

module ioManager
    import ioPkg::*;
(
    input  logic                                          sys_clk,
    input  logic                                          rstN,
    input  logic                                          commandAck,
    input  ioCommandT                                     command,
    output logic                                          commandReq,
    output logic                                          writebackAck,
    input  logic                                          writebackReq,
    output ioWritebackT                                   writeback,
    input  logic [`IO_PORT_COUNT-1:0][`IO_DATA_WIDTH-1:0] portIn,
    output logic [`IO_PORT_COUNT-1:0][`IO_DATA_WIDTH-1:0] portOut
);

    ioDeviceCmdT                        deviceCmd;
    logic [`IO_TIMER_COUNT-1:0]         timerValid;
    logic [`IO_TIMER_COUNT-1:0]         timerReady;
    logic [`IO_PORT_COUNT-1:0]          portValid;
    logic [`IO_PORT_COUNT-1:0]          portReady;
    // Timers take the low source slots, ports the high ones
    ioWritebackT [`IO_SOURCE_COUNT-1:0] sourceData;
    logic [`IO_SOURCE_COUNT-1:0]        sourceValid;
    logic [`IO_SOURCE_COUNT-1:0]        sourceGrant;

    commandRouter router (
        .sys_clk   (sys_clk),
        .rstN      (rstN),
        .commandAck(commandAck),
        .command   (command),
        .commandReq(commandReq),
        .deviceCmd (deviceCmd),
        .timerValid(timerValid),
        .portValid (portValid),
        .timerReady(timerReady),
        .portReady (portReady)
    );

    ioTimers timers (
        .sys_clk      (sys_clk),
        .rstN         (rstN),
        .deviceCmd    (deviceCmd),
        .timerValid   (timerValid),
        .timerReady   (timerReady),
        .response     (sourceData[`IO_TIMER_COUNT-1:0]),
        .responseValid(sourceValid[`IO_TIMER_COUNT-1:0]),
        .grant        (sourceGrant[`IO_TIMER_COUNT-1:0])
    );

    for (genvar p = 0; p < `IO_PORT_COUNT; p++) begin : genPort
        portController portCtrl (
            .sys_clk      (sys_clk),
            .rstN         (rstN),
            .deviceCmd    (deviceCmd),
            .cmdValid     (portValid[p]),
            .cmdReady     (portReady[p]),
            .pinsIn       (portIn[p]),
            .pinsOut      (portOut[p]),
            .response     (sourceData[`IO_TIMER_COUNT + p]),
            .responseValid(sourceValid[`IO_TIMER_COUNT + p]),
            .grant        (sourceGrant[`IO_TIMER_COUNT + p])
        );
    end

    writebackArbiter arbiter (
        .sys_clk     (sys_clk),
        .rstN        (rstN),
        .sourceData  (sourceData),
        .sourceValid (sourceValid),
        .grant       (sourceGrant),
        .writebackAck(writebackAck),
        .writebackReq(writebackReq),
        .writeback   (writeback)
    );

endmodule

/* verification/ioManager_props.sv */
`timescale 1ns/1ps
`include "ioCfg.svh"

module ioManager_props
    import ioPkg::*;
(
    input logic                        sys_clk,
    input logic                        rstN,
    input logic                        commandReq,
    input logic                        writebackAck,
    input logic                        writebackReq,
    input ioWritebackT                 writeback,
    input logic [`IO_SOURCE_COUNT-1:0] sourceGrant
);

    // Number of failed assertions so far
    int failCount = 0;

    // Core stalls the writeback, so ack and payload must hold
    payloadStable: assert property (@(posedge sys_clk) disable iff (!rstN)
        writebackAck && !writebackReq |=> writebackAck && $stable(writeback))
    else begin
        failCount++;
        $error("writeback changed while writebackReq was low");
    end

    // Router stays closed in the first cycle out of reset
    closedAfterReset: assert property (@(posedge sys_clk) $rose(rstN) |-> !commandReq)
    else begin
        failCount++;
        $error("commandReq was high in the first cycle after reset");
    end

    grantOneHot: assert property (@(posedge sys_clk) disable iff (!rstN)
        $onehot0(sourceGrant))
    else begin
        failCount++;
        $error("arbiter granted more than one source");
    end

endmodule

bind ioManager ioManager_props props (.*);

/* verification/ioManager_tb.sv */
`timescale 1ns/1ps
`include "ioCfg.svh"

module ioManager_tb
    import ioPkg::*;
();

    localparam int CommandWords     = 5;
    localparam int MaxCommands      = 64;
    localparam int MemDepth         = `IO_PORT_COUNT + CommandWords * MaxCommands;
    localparam int CyclesPerCommand = 64;
    localparam int SettleCycles     = 16;

    logic                                          sys_clk;
    logic                                          rstN;
    logic                                          commandAck;
    ioCommandT                                     command;
    logic                                          commandReq;
    logic                                          writebackAck;
    logic                                          writebackReq;
    ioWritebackT                                   writeback;
    logic [`IO_PORT_COUNT-1:0][`IO_DATA_WIDTH-1:0] portIn;
    logic [`IO_PORT_COUNT-1:0][`IO_DATA_WIDTH-1:0] portOut;

    logic [`IO_DATA_WIDTH-1:0] stimMem [MemDepth];
    // Expected register state, updated in command order
    logic [`IO_DATA_WIDTH-1:0] modelPortOut [`IO_PORT_COUNT];
    logic [`IO_DATA_WIDTH-1:0] modelReload [`IO_TIMER_COUNT];
    // Scoreboard by destReg
    logic [`IO_DATA_WIDTH-1:0] expData [16];
    bit                        expPending [16];
    int                        cmdCount = 0;
    int                        expectedCount = 0;
    int                        receivedCount = 0;
    int                        cycleCount = 0;
    int                        cycleLimit = CyclesPerCommand * MaxCommands;
    bit                        settling = 1'b0;

    ioManager uut (.*);

    initial sys_clk = 1'b0;
    always #5 sys_clk = ~sys_clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkIoWriteback(input string name, input ioWritebackT actual,
                                    input ioWritebackT expected);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch on %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic checkPortOut(input int index, input logic [`IO_DATA_WIDTH-1:0] actual,
                                input logic [`IO_DATA_WIDTH-1:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("Mismatch on portOut[%0d]: got %h, expected %h",
                              index, actual, expected));
        end
    endtask

    // Store wins when both opcode bits are set
    function automatic ioKindE decodeKind(input logic [3:0] opcode);
        return opcode[2] ? ioKindStore : (opcode[3] ? ioKindLoad : ioKindNone);
    endfunction

    // Source index of an address, or -1 outside the window
    function automatic int decodeTarget(input logic [`IO_DATA_WIDTH-1:0] address);
        int offset;
        offset = int'(address) - `IO_BASE_ADDR;
        return (offset >= 0 && offset < `IO_SOURCE_COUNT) ? offset : -1;
    endfunction

    task automatic predictCommand(input int index, input ioCommandT cmd, input logic flag);
        ioKindE kind;
        int     target;
        bit     respond;
        kind    = decodeKind(cmd.minorOpcode);
        target  = decodeTarget(cmd.address);
        // Mapped loads answer at once, timer stores answer on expiry
        respond = target >= 0 && (kind == ioKindLoad
                  || (kind == ioKindStore && target < `IO_TIMER_COUNT));
        if (respond != flag) begin
            failRun($sformatf("Input command %0d has response flag %0d but decodes to %0d",
                              index, flag, respond));
        end else if (respond && expPending[cmd.destReg]) begin
            failRun($sformatf("Input command %0d reuses pending destReg %h",
                              index, cmd.destReg));
        end else begin
            if (respond) begin
                expPending[cmd.destReg] = 1'b1;
                expectedCount++;
                if (kind == ioKindStore) begin
                    expData[cmd.destReg] = cmd.data;
                end else if (target < `IO_TIMER_COUNT) begin
                    expData[cmd.destReg] = modelReload[target];
                end else begin
                    expData[cmd.destReg] = portIn[target - `IO_TIMER_COUNT];
                end
            end
            if (kind == ioKindStore && target >= 0) begin
                if (target < `IO_TIMER_COUNT) begin
                    modelReload[target] = cmd.data;
                end else begin
                    modelPortOut[target - `IO_TIMER_COUNT] = cmd.data;
                end
            end
        end
    endtask

    task automatic recordWriteback(input ioWritebackT wb);
        ioWritebackT expected;
        if (!expPending[wb.destReg]) begin
            failRun($sformatf("Unexpected writeback to destReg %h carrying %h",
                              wb.destReg, wb.data));
        end else begin
            expected = '{destReg: wb.destReg, data: expData[wb.destReg]};
            checkIoWriteback("writeback", wb, expected);
            expPending[wb.destReg] = 1'b0;
            receivedCount <= receivedCount + 1;
        end
    endtask

    // Command is held until commandReq is seen on an edge
    task automatic sendCommand(input ioCommandT cmd);
        commandAck <= 1'b1;
        command    <= cmd;
        do begin
            @(posedge sys_clk);
        end while (!commandReq);
    endtask

    initial begin
        int        base;
        int        target;
        int        maxReload;
        ioCommandT cmd;
        rstN       = 1'b0;
        commandAck = 1'b0;
        command    = '0;
        $readmemh("verification/ioManager_input.txt", stimMem);
        for (int p = 0; p < `IO_PORT_COUNT; p++) begin
            portIn[p]       = stimMem[p];
            modelPortOut[p] = '0;
        end
        modelReload = '{default: '0};
        // Budget grows with the command count and the longest countdown
        maxReload = 0;
        base = `IO_PORT_COUNT;
        while (base + CommandWords <= MemDepth && !$isunknown(stimMem[base])) begin
            target = decodeTarget(stimMem[base + 1]);
            if (decodeKind(stimMem[base][3:0]) == ioKindStore && target >= 0
                    && target < `IO_TIMER_COUNT && int'(stimMem[base + 2]) > maxReload) begin
                maxReload = int'(stimMem[base + 2]);
            end
            cmdCount++;
            base += CommandWords;
        end
        cycleLimit = CyclesPerCommand * cmdCount + maxReload;
        if (cmdCount == 0) begin
            failRun("The input file holds no commands");
        end
        repeat (5) @(posedge sys_clk);
        rstN <= 1'b1;
        for (int n = 0; n < cmdCount; n++) begin
            base = `IO_PORT_COUNT + CommandWords * n;
            cmd = '{minorOpcode: stimMem[base][3:0], address: stimMem[base + 1],
                    data: stimMem[base + 2], destReg: stimMem[base + 3][3:0]};
            predictCommand(n, cmd, stimMem[base + 4][0]);
            sendCommand(cmd);
        end
        commandAck <= 1'b0;
        while (receivedCount < expectedCount) begin
            @(posedge sys_clk);
        end
        // Quiet window catches stray writebacks and lets the last store land
        settling <= 1'b1;
        repeat (SettleCycles) @(posedge sys_clk);
        // Assertions on the last edge have finished by the falling edge
        @(negedge sys_clk);
        for (int p = 0; p < `IO_PORT_COUNT; p++) begin
            checkPortOut(p, portOut[p], modelPortOut[p]);
        end
        if (uut.props.failCount != 0) begin
            failRun("A bound handshake assertion failed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    // Random back-pressure on the writeback channel
    initial begin
        writebackReq = 1'b0;
        void'($urandom(32'hf02d));
        forever begin
            @(posedge sys_clk);
            writebackReq <= settling || ($urandom % 3 != 0);
        end
    end

    always @(posedge sys_clk) begin
        if (rstN && writebackAck && writebackReq) begin
            recordWriteback(writeback);
        end
    end

    always @(posedge sys_clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            failRun($sformatf("Timeout after %0d cycles before the run completed", cycleLimit));
        end else if (uut.props.failCount != 0) begin
            failRun("A bound handshake assertion failed");
        end
    end

endmodule

/* ioManager.f */
+incdir+hdl
hdl/ioPkg.sv
hdl/commandRouter.sv
hdl/ioTimers.sv
hdl/portController.sv
hdl/writebackArbiter.sv
hdl/ioManager.sv
verification/ioManager_props.sv
verification/ioManager_tb.sv

/* verification/ioManager_input.txt */
// Four portIn words, port 0 first
// Then one command per line: minorOpcode address data destReg expectResponse
A5A5
5A5A
1234
FEDC
4 0184 BEEF 0 0 // port 0 store
4 0185 C0DE 0 0
8 0186 0000 1 1 // port 2 load
4 0180 0010 2 1 // timer 0 counts down from 16
4 0181 0000 3 1 // timer 1 with zero reload
8 0180 0000 4 1
4 0187 0F0F 0 0
8 0184 0000 5 1 // load returns pins, not the output register
0 0185 FFFF 0 0 // none kind
4 0188 DEAD 0 0 // above the window
8 017F 0000 0 0 // below the window
4 0182 0030 6 1
C 0183 0005 7 1 // both bits set decodes as store
8 0187 0000 8 1
8 0185 0000 9 1
A 0181 0000 A 1
4 0184 1111 0 0
8 0183 0000 B 1
3 0186 7777 0 0 // none kind on port 2
8 0184 0000 C 1
8 0182 0000 D 1
4 0181 0003 E 1 // timer 1 restarted
8 0186 0000 F 1
